//--- design/irda_macros.svh
`ifndef IRDA_MACROS_SVH
`define IRDA_MACROS_SVH

// SIP waveform phase lengths in clocks, each phase lasts count+1 cycles
`define IRDA_SIP_HIGH_CLOCKS 320	// 1.6 us at 200 MHz
`define IRDA_SIP_LOW_CLOCKS 1420	// low gap after the pulse
`define IRDA_SIP_END_CLOCKS 200	// end window, 1 us

// generator down counter must hold the largest phase count
`define IRDA_SIP_CNT_W 11

// clocks between scheduled SIPs in MIR and FIR mode
`define IRDA_SIP_INTERVAL 4000

// scheduler interval counter width
`define IRDA_INTERVAL_W 16

`endif

//--- design/irda_pkg.sv
package irda_pkg;

	// link mode as seen by the SIP scheduler
	typedef enum logic [1:0]
	{
		MODE_SIR = 2'd0,	// no SIP needed
		MODE_MIR = 2'd1,
		MODE_FIR = 2'd2
		// code 3 reserved, behaves as SIR
	} irda_mode_t;

	// SIP generator phases
	typedef enum logic [1:0]
	{
		ST_IDLE     = 2'd0,
		ST_HIGH     = 2'd1,	// pulse on the line
		ST_LOW      = 2'd2,	// quiet gap
		ST_SEND_END = 2'd3	// end window toward the scheduler
	} sip_state_t;

endpackage

//--- design/irda_sip_if.sv
`timescale 1ns/1ps

interface irda_sip_if;

	logic mir_sip;	// mir mode sip request level
	logic fir_sip;	// fir mode sip request level
	logic sip_end;	// end of sip window
	logic sip_gen;	// sip waveform

	modport sched
	(
		output mir_sip,
		output fir_sip,
		input  sip_end,
		input  sip_gen
	);

	modport gen
	(
		input  mir_sip,
		input  fir_sip,
		output sip_end,
		output sip_gen
	);

endinterface

//--- design/irda_sip_gen.sv
`timescale 1ns/1ps
`include "irda_macros.svh"

module irda_sip_gen #(
	parameter int high_clocks    = `IRDA_SIP_HIGH_CLOCKS,
	parameter int low_clocks     = `IRDA_SIP_LOW_CLOCKS,
	parameter int sip_end_clocks = `IRDA_SIP_END_CLOCKS
) (
	input  logic       clk,
	input  logic       wb_rst_i,
	irda_sip_if.gen    sip
);

	logic [`IRDA_SIP_CNT_W-1:0] sip_counter;
	logic                       sip_delay;	// inverted request of last cycle
	logic                       sip_any;	// either mode requests
	logic                       sip_req;	// rising edge of the request
	irda_pkg::sip_state_t       state;

	assign sip_any = sip.mir_sip | sip.fir_sip;

	// rise detection on the combined request
	always_ff @(posedge clk or posedge wb_rst_i)
	begin
		if (wb_rst_i)
			sip_delay <= 1'b0;
		else
			sip_delay <= ~sip_any;
	end

	assign sip_req = sip_delay & sip_any;

	// one down counter walks high, low and end phases
	// a new rise restarts the waveform from the high phase
	always_ff @(posedge clk or posedge wb_rst_i)
	begin
		if (wb_rst_i)
		begin
			state       <= irda_pkg::ST_IDLE;
			sip_counter <= '0;
			sip.sip_gen <= 1'b0;
			sip.sip_end <= 1'b0;
		end
		else if (sip_req)
		begin
			state       <= irda_pkg::ST_HIGH;
			sip_counter <= `IRDA_SIP_CNT_W'(high_clocks);	// start of pulse
		end
		else
		begin
			case (state)
				irda_pkg::ST_IDLE:
				begin
					sip.sip_gen <= 1'b0;
					sip.sip_end <= 1'b0;
				end
				irda_pkg::ST_HIGH:
				begin
					sip.sip_gen <= 1'b1;
					if (sip_counter != '0)
						sip_counter <= sip_counter - 1'b1;
					else
					begin
						state       <= irda_pkg::ST_LOW;
						sip_counter <= `IRDA_SIP_CNT_W'(low_clocks);
					end
				end
				irda_pkg::ST_LOW:
				begin
					sip.sip_gen <= 1'b0;
					if (sip_counter != '0)
						sip_counter <= sip_counter - 1'b1;
					else
					begin
						state       <= irda_pkg::ST_SEND_END;
						sip.sip_end <= 1'b1;	// open end window
						sip_counter <= `IRDA_SIP_CNT_W'(sip_end_clocks);
					end
				end
				irda_pkg::ST_SEND_END:
				begin
					sip.sip_gen <= 1'b0;
					if (sip_counter != '0)
						sip_counter <= sip_counter - 1'b1;
					else
					begin
						state       <= irda_pkg::ST_IDLE;
						sip.sip_end <= 1'b0;
						sip_counter <= '0;
					end
				end
				default:
				begin
					state <= irda_pkg::ST_IDLE;
				end
			endcase
		end
	end

endmodule

//--- design/irda_sip_ctrl.sv
`timescale 1ns/1ps
`include "irda_macros.svh"

module irda_sip_ctrl (
	input  logic                 clk,
	input  logic                 wb_rst_i,
	input  irda_pkg::irda_mode_t mode_i,
	input  logic                 sip_force_i,	// one cycle strobe
	input  logic                 tx_active_i,	// frame being sent
	input  logic                 tx_bit_i,	// encoded frame bit
	output logic                 tx_o,
	output logic                 sip_busy_o,
	output logic                 sip_done_o,
	irda_sip_if.sched            sip
);

	logic [`IRDA_INTERVAL_W-1:0] interval_cnt;
	logic                        sip_mode;	// mir or fir selected
	logic                        interval_hit;
	logic                        sip_pending;
	logic                        sip_start;
	logic                        sip_req;
	logic                        sip_busy;
	logic                        sip_end_d;
	logic                        sip_end_fall;

	assign sip_mode = (mode_i == irda_pkg::MODE_MIR) || (mode_i == irda_pkg::MODE_FIR);

	assign interval_hit = (interval_cnt == `IRDA_INTERVAL_W'(`IRDA_SIP_INTERVAL));

	// pending sip waits for an idle transmitter
	assign sip_start = sip_pending & sip_mode & ~tx_active_i & ~sip_busy;

	assign sip_end_fall = sip_end_d & ~sip.sip_end;

	// interval timer, held while a sip is waiting or running
	always_ff @(posedge clk or posedge wb_rst_i)
	begin
		if (wb_rst_i)
			interval_cnt <= '0;
		else if (!sip_mode || sip_busy || interval_hit)
			interval_cnt <= '0;
		else if (!sip_pending)
			interval_cnt <= interval_cnt + 1'b1;
	end

	always_ff @(posedge clk or posedge wb_rst_i)
	begin
		if (wb_rst_i)
			sip_pending <= 1'b0;
		else if (!sip_mode)
			sip_pending <= 1'b0;	// sir needs no sip
		else if (sip_start)
			sip_pending <= 1'b0;
		else if (interval_hit || sip_force_i)
			sip_pending <= 1'b1;
	end

	// request level and busy span, request drops once the end window shows
	always_ff @(posedge clk or posedge wb_rst_i)
	begin
		if (wb_rst_i)
		begin
			sip_req  <= 1'b0;
			sip_busy <= 1'b0;
		end
		else if (!sip_mode)
		begin
			sip_req  <= 1'b0;
			sip_busy <= 1'b0;
		end
		else if (sip_start)
		begin
			sip_req  <= 1'b1;
			sip_busy <= 1'b1;
		end
		else
		begin
			if (sip.sip_end)
				sip_req <= 1'b0;
			if (sip_end_fall)
				sip_busy <= 1'b0;	// end window closed
		end
	end

	// steer onto the line of the current mode
	assign sip.mir_sip = sip_req & (mode_i == irda_pkg::MODE_MIR);
	assign sip.fir_sip = sip_req & (mode_i == irda_pkg::MODE_FIR);

	always_ff @(posedge clk or posedge wb_rst_i)
	begin
		if (wb_rst_i)
		begin
			sip_end_d  <= 1'b0;
			sip_done_o <= 1'b0;
		end
		else
		begin
			sip_end_d  <= sip.sip_end;
			sip_done_o <= sip_end_fall;
		end
	end

	// transmit line, sip hides any frame bit
	always_ff @(posedge clk or posedge wb_rst_i)
	begin
		if (wb_rst_i)
			tx_o <= 1'b0;
		else if (sip_busy)
			tx_o <= sip.sip_gen;
		else if (tx_active_i)
			tx_o <= tx_bit_i;
		else
			tx_o <= 1'b0;
	end

	assign sip_busy_o = sip_busy;

endmodule

//--- design/irda_sip_top.sv
`timescale 1ns/1ps
`include "irda_macros.svh"

module irda_sip_top (
	input  logic       clk,
	input  logic       wb_rst_i,
	input  logic [1:0] mode_i,	// 0 sir, 1 mir, 2 fir
	input  logic       sip_force_i,
	input  logic       tx_active_i,
	input  logic       tx_bit_i,
	output logic       tx_o,
	output logic       sip_busy_o,
	output logic       sip_done_o
);

	irda_sip_if sip_bus ();

	// scheduler and line mux
	irda_sip_ctrl u_ctrl (
		.clk         (clk),
		.wb_rst_i    (wb_rst_i),
		.mode_i      (irda_pkg::irda_mode_t'(mode_i)),
		.sip_force_i (sip_force_i),
		.tx_active_i (tx_active_i),
		.tx_bit_i    (tx_bit_i),
		.tx_o        (tx_o),
		.sip_busy_o  (sip_busy_o),
		.sip_done_o  (sip_done_o),
		.sip         (sip_bus.sched)
	);

	// waveform generator
	irda_sip_gen #(
		.high_clocks    (`IRDA_SIP_HIGH_CLOCKS),
		.low_clocks     (`IRDA_SIP_LOW_CLOCKS),
		.sip_end_clocks (`IRDA_SIP_END_CLOCKS)
	) u_gen (
		.clk      (clk),
		.wb_rst_i (wb_rst_i),
		.sip      (sip_bus.gen)
	);

endmodule

//--- sim/irda_sip_assertions.sv
`timescale 1ns/1ps

module irda_sip_assertions (
	input logic                 clk,
	input logic                 wb_rst_i,
	input logic [1:0]           mode_i,
	input logic                 tx_active_i,
	input logic                 tx_line_i,	// dut tx_o
	input logic                 sip_busy_i,
	input logic                 sip_done_i,
	input logic                 mir_sip_i,
	input logic                 fir_sip_i,
	input logic                 sip_end_i,
	input irda_pkg::sip_state_t gen_state_i
);

	int   fail_count = 0;	// read by the testbench summary
	logic sip_mode;

	assign sip_mode = (mode_i == irda_pkg::MODE_MIR) || (mode_i == irda_pkg::MODE_FIR);

	// outside a sip the line only carries frame bits
	frame_only_a: assert property (@(posedge clk) disable iff (wb_rst_i)
		(tx_line_i && !sip_busy_i) |-> $past(tx_active_i))
	else
	begin
		$error("tx_o high outside a sip without an active frame");
		fail_count++;
	end

	// a request level never survives a cycle of sir mode
	sir_quiet_a: assert property (@(posedge clk) disable iff (wb_rst_i)
		!sip_mode |=> !(mir_sip_i || fir_sip_i))
	else
	begin
		$error("sip request raised in sir mode");
		fail_count++;
	end

	done_single_a: assert property (@(posedge clk) disable iff (wb_rst_i)
		sip_done_i |=> !sip_done_i)
	else
	begin
		$error("sip_done_o held for two cycles");
		fail_count++;
	end

	// end window only while the generator sits in its end state
	end_window_a: assert property (@(posedge clk) disable iff (wb_rst_i)
		sip_end_i |-> (gen_state_i == irda_pkg::ST_SEND_END))
	else
	begin
		$error("sip_end high outside the end state");
		fail_count++;
	end

endmodule

bind irda_sip_top irda_sip_assertions u_assert (
	.clk         (clk),
	.wb_rst_i    (wb_rst_i),
	.mode_i      (mode_i),
	.tx_active_i (tx_active_i),
	.tx_line_i   (tx_o),
	.sip_busy_i  (sip_busy_o),
	.sip_done_i  (sip_done_o),
	.mir_sip_i   (sip_bus.mir_sip),
	.fir_sip_i   (sip_bus.fir_sip),
	.sip_end_i   (sip_bus.sip_end),
	.gen_state_i (u_gen.state)
);

//--- sim/irda_sip_tb.sv
`timescale 1ns/1ps
`include "irda_macros.svh"

module irda_sip_tb;

	localparam int high_len  = `IRDA_SIP_HIGH_CLOCKS + 1;	// pulse width on the line
	localparam int done_gap  = `IRDA_SIP_LOW_CLOCKS + `IRDA_SIP_END_CLOCKS + 1;	// line fall to done
	localparam int force_lat = 4;	// pending, request, generator, line register
	localparam int defer_lat = 3;	// pending already set
	localparam int sip_len   = `IRDA_SIP_HIGH_CLOCKS + `IRDA_SIP_LOW_CLOCKS
		+ `IRDA_SIP_END_CLOCKS + 3;
	// whole run is about three intervals and four sips, doubled for margin
	localparam int max_cycles = 2 * (3 * `IRDA_SIP_INTERVAL + 4 * sip_len);

	logic       clk;
	logic       wb_rst_i;
	logic [1:0] mode_i;
	logic       sip_force_i;
	logic       tx_active_i;
	logic       tx_bit_i;
	logic       tx_o;
	logic       sip_busy_o;
	logic       sip_done_o;

	integer      seed;
	logic [31:0] rnd;
	int          cycle;
	int          errors;
	int          tests;
	int          test_start_errors;
	int          assert_fails;

	irda_sip_top uut (
		.clk         (clk),
		.wb_rst_i    (wb_rst_i),
		.mode_i      (mode_i),
		.sip_force_i (sip_force_i),
		.tx_active_i (tx_active_i),
		.tx_bit_i    (tx_bit_i),
		.tx_o        (tx_o),
		.sip_busy_o  (sip_busy_o),
		.sip_done_o  (sip_done_o)
	);

	initial
	begin
		clk = 1'b0;
		forever
			#50 clk = ~clk;
	end

	// watchdog
	initial
	begin
		cycle = 0;
		while (cycle < max_cycles)
		begin
			@(posedge clk);
			cycle = cycle + 1;
		end
		$display("timeout: run did not finish within %0d cycles", max_cycles);
		$display("Finished with errors");
		$finish;
	end

	task automatic expect_bit(input string name, input logic got, input logic exp);
		assert (got === exp)
		else
		begin
			$display("mismatch: %s is 0x%0h, expected 0x%0h (cycle %0d)", name, got, exp, cycle);
			errors++;
		end
	endtask

	task automatic expect_int(input string name, input int got, input int exp);
		assert (got == exp)
		else
		begin
			$display("mismatch: %s is 0x%0h, expected 0x%0h (cycle %0d)", name, got, exp, cycle);
			errors++;
		end
	endtask

	task automatic note_test_start();
		test_start_errors = errors;
	endtask

	task automatic report_test(input string name);
		tests++;
		$display("test %s done, %0d errors", name, errors - test_start_errors);
	endtask

	task automatic next_frame_bit();
		rnd = $random(seed);
		tx_bit_i = rnd[0];
	endtask

	// entered on the first cycle that shows the pulse on tx_o
	task automatic check_sip_pulse();
		int width;
		int gap;
		width = 1;
		expect_bit("sip_busy_o", sip_busy_o, 1'b1);
		@(negedge clk);
		while (tx_o && width < high_len + 8)
		begin
			expect_bit("sip_busy_o", sip_busy_o, 1'b1);
			width++;
			@(negedge clk);
		end
		expect_int("tx_o pulse width", width, high_len);
		gap = 0;
		while (!sip_done_o && gap < done_gap + 8)
		begin
			expect_bit("tx_o", tx_o, 1'b0);	// low gap and end window
			expect_bit("sip_busy_o", sip_busy_o, 1'b1);
			gap++;
			@(negedge clk);
		end
		assert (sip_done_o)
		else
		begin
			$display("error: sip_done_o never pulsed after the sip (cycle %0d)", cycle);
			errors++;
		end
		if (sip_done_o)
			expect_int("sip_done_o delay", gap, done_gap);
		@(negedge clk);
		expect_bit("sip_done_o", sip_done_o, 1'b0);	// single cycle pulse
		expect_bit("sip_busy_o", sip_busy_o, 1'b0);
	endtask

	task automatic check_reset();
		note_test_start();
		repeat (3)
		begin
			@(negedge clk);
			expect_bit("tx_o", tx_o, 1'b0);
			expect_bit("sip_busy_o", sip_busy_o, 1'b0);
			expect_bit("sip_done_o", sip_done_o, 1'b0);
		end
		wb_rst_i = 1'b0;
		repeat (4)
		begin
			@(negedge clk);
			expect_bit("tx_o", tx_o, 1'b0);
			expect_bit("sip_busy_o", sip_busy_o, 1'b0);
			expect_bit("sip_done_o", sip_done_o, 1'b0);
		end
		report_test("reset");
	endtask

	task automatic forced_mir_sip();
		int i;
		note_test_start();
		@(negedge clk);
		mode_i      = irda_pkg::MODE_MIR;
		tx_active_i = 1'b0;
		sip_force_i = 1'b1;
		for (i = 1; i <= force_lat + 1; i++)
		begin
			@(negedge clk);
			sip_force_i = 1'b0;
			expect_bit("tx_o", tx_o, (i > force_lat));
		end
		check_sip_pulse();
		report_test("forced_mir");
	endtask

	task automatic periodic_fir_sip();
		int count;
		logic seen;
		note_test_start();
		@(negedge clk);
		mode_i = irda_pkg::MODE_SIR;	// clears the interval timer
		@(negedge clk);
		mode_i = irda_pkg::MODE_FIR;
		count  = 0;
		seen   = 1'b0;
		while (!seen && count < `IRDA_SIP_INTERVAL + 8)
		begin
			@(negedge clk);
			count++;
			if (tx_o)
				seen = 1'b1;
		end
		assert (seen)
		else
		begin
			$display("error: no periodic sip within %0d cycles", count);
			errors++;
		end
		if (seen)
		begin
			assert (count > `IRDA_SIP_INTERVAL)
			else
			begin
				$display("error: periodic sip came early, after %0d cycles", count);
				errors++;
			end
			check_sip_pulse();
		end
		report_test("periodic_fir");
	endtask

	task automatic sir_frame_pass();
		int i;
		logic prev_bit;
		note_test_start();
		@(negedge clk);
		mode_i      = irda_pkg::MODE_SIR;
		tx_active_i = 1'b1;
		next_frame_bit();
		prev_bit = tx_bit_i;
		for (i = 0; i < 2 * `IRDA_SIP_INTERVAL; i++)
		begin
			@(negedge clk);
			expect_bit("tx_o", tx_o, prev_bit);	// one cycle behind the frame bit
			expect_bit("sip_busy_o", sip_busy_o, 1'b0);
			next_frame_bit();
			prev_bit    = tx_bit_i;
			sip_force_i = (i % 500 == 0);	// ignored in sir
		end
		@(negedge clk);
		tx_active_i = 1'b0;
		tx_bit_i    = 1'b0;
		sip_force_i = 1'b0;
		report_test("sir_frames");
	endtask

	task automatic deferred_sip();
		int i;
		logic prev_bit;
		note_test_start();
		@(negedge clk);
		mode_i      = irda_pkg::MODE_MIR;
		tx_active_i = 1'b1;
		next_frame_bit();
		prev_bit = tx_bit_i;
		for (i = 0; i < 200; i++)
		begin
			@(negedge clk);
			expect_bit("tx_o", tx_o, prev_bit);
			expect_bit("sip_busy_o", sip_busy_o, 1'b0);
			next_frame_bit();
			prev_bit    = tx_bit_i;
			sip_force_i = (i == 20);	// strobe while the frame runs
		end
		@(negedge clk);
		expect_bit("tx_o", tx_o, prev_bit);
		expect_bit("sip_busy_o", sip_busy_o, 1'b0);
		tx_active_i = 1'b0;	// frame over, pending sip may start
		tx_bit_i    = 1'b0;
		sip_force_i = 1'b0;
		for (i = 1; i <= defer_lat + 1; i++)
		begin
			@(negedge clk);
			expect_bit("tx_o", tx_o, (i > defer_lat));
		end
		check_sip_pulse();
		@(negedge clk);
		mode_i = irda_pkg::MODE_SIR;
		report_test("deferred");
	endtask

	initial
	begin
		seed        = 32'ha239;
		errors      = 0;
		tests       = 0;
		wb_rst_i    = 1'b1;
		mode_i      = irda_pkg::MODE_SIR;
		sip_force_i = 1'b0;
		tx_active_i = 1'b0;
		tx_bit_i    = 1'b0;
		check_reset();
		forced_mir_sip();
		periodic_fir_sip();
		sir_frame_pass();
		deferred_sip();
		assert_fails = uut.u_assert.fail_count;
		errors       = errors + assert_fails;
		$display("summary: %0d tests, %0d errors, %0d from assertions",
			tests, errors, assert_fails);
		if (errors == 0)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	end

endmodule

//--- tb.f
+incdir+design
design/irda_pkg.sv
design/irda_sip_if.sv
design/irda_sip_gen.sv
design/irda_sip_ctrl.sv
design/irda_sip_top.sv
sim/irda_sip_assertions.sv
sim/irda_sip_tb.sv

//--- run.sh
#!/usr/bin/env bash
# build the SIP testbench with Verilator, run it and check the log
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --timescale 1ns/1ps \
	--top-module irda_sip_tb -f tb.f -o irda_sip_sim

# keep running past assertion errors so the summary is printed
./obj_dir/irda_sip_sim +verilator+error+limit+1000 > sim.log 2>&1 || true
cat sim.log

if grep -q "^Finished with no errors$" sim.log; then
	echo "simulation passed"
else
	echo "simulation failed"
	exit 1
fi
